/* flist.f */
rtl/accel_pkg.sv
rtl/cmd_apb_regs.sv
rtl/cmd_dispatch.sv
rtl/mod_mul_engine.sv
rtl/idx_check_engine.sv
rtl/resp_collect.sv
rtl/accel_top.sv
verif/accel_tb.sv

/* rtl/accel_pkg.sv */
package accel_pkg;

  // Datapath and bus widths
  localparam int WORD_BITS = 32;
  localparam int ADDR_BITS = 8;

  typedef logic [WORD_BITS-1:0] word_t;   // APB data, operands, modulus, result
  typedef logic [ADDR_BITS-1:0] addr_t;   // APB byte address
  typedef logic [1:0]           opcode_t;
  typedef logic [1:0]           err_t;

  // Command opcodes, value 3 is illegal
  localparam opcode_t OP_NOP    = 2'd0;
  localparam opcode_t OP_MODMUL = 2'd1;
  localparam opcode_t OP_IDXCHK = 2'd2;

  // Completion error codes
  localparam err_t ERR_NONE   = 2'd0;
  localparam err_t ERR_BAD_OP = 2'd1;
  localparam err_t ERR_RANGE  = 2'd2;

  // Register map
  localparam addr_t REG_CMD    = 8'h00;
  localparam addr_t REG_OPA    = 8'h04;
  localparam addr_t REG_OPB    = 8'h08;
  localparam addr_t REG_MOD    = 8'h0C;
  localparam addr_t REG_STATUS = 8'h10;
  localparam addr_t REG_RESULT = 8'h14;

  localparam int CMD_USR_RST_BIT = 31;   // Command word bit requesting user reset

  // Index checker geometry
  localparam int IDX_BITS     = 4;
  localparam int IDX_COUNT    = 8;
  localparam int IDX_PAIRS    = IDX_COUNT / 2;
  localparam int IDX_SEEN     = 2 ** IDX_BITS;      // One seen flag per index value
  localparam int IDX_CNT_BITS = $clog2(IDX_COUNT);

  // Multiplier bit counter width
  localparam int MUL_CNT_BITS = $clog2(WORD_BITS);

  // Shared engine FSM
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } eng_state_t;

endpackage

/* rtl/accel_top.sv */
`timescale 1ns/100ps

module accel_top
  import accel_pkg::*;
(
  input  logic  i_clk_core0,
  input  logic  i_reset,
  // APB slave
  input  logic  i_psel,
  input  logic  i_penable,
  input  logic  i_pwrite,
  input  addr_t i_paddr,
  input  word_t i_pwdata,
  output word_t o_prdata,
  output logic  o_pready,
  output logic  o_pslverr
);

  logic    usr_rst, usr_rst_r, rst_core;
  logic    start, busy, done;
  opcode_t opcode;
  word_t   opa, opb, mod;
  logic    mm_start, ic_start, mm_valid, ic_valid;
  word_t   op_a, op_b, op_m;
  word_t   mm_result, ic_result, result;
  logic    err_pulse, clr;
  err_t    disp_err, col_err;

  // User reset registered once, then merged with the board reset
  always_ff @(posedge i_clk_core0) begin
    if (i_reset) usr_rst_r <= 1'b0;
    else         usr_rst_r <= usr_rst;
  end

  assign rst_core = i_reset | usr_rst_r;   // Core only, front end keeps its registers

  // Front end sits on i_reset alone
  cmd_apb_regs u_regs (
    .i_clk_core0 (i_clk_core0), .i_reset (i_reset),
    .i_psel      (i_psel),      .i_penable (i_penable), .i_pwrite (i_pwrite),
    .i_paddr     (i_paddr),     .i_pwdata  (i_pwdata),
    .o_prdata    (o_prdata),    .o_pready  (o_pready),  .o_pslverr (o_pslverr),
    .i_busy      (busy),        .i_done    (done),      .i_err     (col_err),
    .i_result    (result),
    .o_start     (start),       .o_opcode  (opcode),
    .o_opa       (opa),         .o_opb     (opb),       .o_mod     (mod),
    .o_usr_rst   (usr_rst)
  );

  cmd_dispatch u_dispatch (
    .i_clk_core0 (i_clk_core0), .i_reset    (rst_core),
    .i_start     (start),       .i_opcode   (opcode),
    .i_opa       (opa),         .i_opb      (opb),      .i_mod   (mod),
    .o_busy      (busy),        .o_mm_start (mm_start), .o_ic_start (ic_start),
    .o_op_a      (op_a),        .o_op_b     (op_b),     .o_op_m  (op_m),
    .i_mm_valid  (mm_valid),    .i_ic_valid (ic_valid),
    .o_err_pulse (err_pulse),   .o_err      (disp_err), .o_clr   (clr)
  );

  mod_mul_engine u_mod_mul (
    .i_clk_core0 (i_clk_core0), .i_reset (rst_core), .i_start (mm_start),
    .i_a         (op_a),        .i_b     (op_b),     .i_m     (op_m),
    .o_valid     (mm_valid),    .o_result (mm_result)
  );

  // Index list rides in operand A
  idx_check_engine u_idx_check (
    .i_clk_core0 (i_clk_core0), .i_reset    (rst_core), .i_start (ic_start),
    .i_idx_list  (op_a),        .o_valid    (ic_valid), .o_result (ic_result)
  );

  resp_collect u_collect (
    .i_clk_core0 (i_clk_core0), .i_reset     (rst_core), .i_clr (clr),
    .i_mm_valid  (mm_valid),    .i_mm_result (mm_result),
    .i_ic_valid  (ic_valid),    .i_ic_result (ic_result),
    .i_err_pulse (err_pulse),   .i_err       (disp_err),
    .o_done      (done),        .o_err       (col_err),  .o_result (result)
  );

endmodule

/* rtl/cmd_apb_regs.sv */
`timescale 1ns/100ps

module cmd_apb_regs
  import accel_pkg::*;
(
  input  logic    i_clk_core0,
  input  logic    i_reset,
  // APB slave
  input  logic    i_psel,
  input  logic    i_penable,
  input  logic    i_pwrite,
  input  addr_t   i_paddr,
  input  word_t   i_pwdata,
  output word_t   o_prdata,
  output logic    o_pready,
  output logic    o_pslverr,
  // Status and result from the core
  input  logic    i_busy,
  input  logic    i_done,
  input  err_t    i_err,
  input  word_t   i_result,
  // Command towards the dispatcher
  output logic    o_start,
  output opcode_t o_opcode,
  output word_t   o_opa,
  output word_t   o_opb,
  output word_t   o_mod,
  output logic    o_usr_rst
);

  logic acc_ph;       // APB access phase
  logic mapped;       // Address hits a register
  logic cmd_wr;       // Write to the command register
  logic usr_req;      // Command word carries the user reset bit
  logic busy_eff;
  logic cmd_refused;
  logic wr_ok;        // Write that is allowed to change state

  assign acc_ph   = i_psel & i_penable;
  assign o_pready = acc_ph;             // Never any wait states

  // Start pulse in flight counts as busy until the dispatcher catches up
  assign busy_eff = i_busy | o_start;

  assign cmd_wr      = acc_ph & i_pwrite & (i_paddr == REG_CMD);
  assign usr_req     = i_pwdata[CMD_USR_RST_BIT];
  assign cmd_refused = cmd_wr & busy_eff & ~usr_req;   // User reset always gets through

  assign o_pslverr = acc_ph & (~mapped | cmd_refused);
  assign wr_ok     = acc_ph & i_pwrite & ~o_pslverr;

  // Address decode and read mux
  always_comb begin
    mapped   = 1'b1;
    o_prdata = '0;
    case (i_paddr)
      REG_CMD:    o_prdata = word_t'(o_opcode);
      REG_OPA:    o_prdata = o_opa;
      REG_OPB:    o_prdata = o_opb;
      REG_MOD:    o_prdata = o_mod;
      REG_STATUS: o_prdata = word_t'({i_err, i_done, i_busy});   // err[3:2] done[1] busy[0]
      REG_RESULT: o_prdata = i_result;
      default:    mapped   = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk_core0) begin
    if (i_reset) begin
      o_start   <= 1'b0;
      o_usr_rst <= 1'b0;
      o_opcode  <= OP_NOP;
      o_opa     <= '0;
      o_opb     <= '0;
      o_mod     <= '0;
    end else begin
      o_start   <= 1'b0;   // Pulses last one cycle
      o_usr_rst <= 1'b0;
      if (wr_ok) begin
        case (i_paddr)
          REG_CMD: begin
            if (usr_req) begin
              o_usr_rst <= 1'b1;   // Reset only, opcode left alone
            end else begin
              o_opcode <= opcode_t'(i_pwdata[$bits(opcode_t)-1:0]);
              o_start  <= 1'b1;
            end
          end
          REG_OPA: o_opa <= i_pwdata;
          REG_OPB: o_opb <= i_pwdata;
          REG_MOD: o_mod <= i_pwdata;
          default: ;   // Status and result are read only
        endcase
      end
    end
  end

endmodule

/* rtl/cmd_dispatch.sv */
`timescale 1ns/100ps

module cmd_dispatch
  import accel_pkg::*;
(
  input  logic    i_clk_core0,
  input  logic    i_reset,
  input  logic    i_start,
  input  opcode_t i_opcode,
  input  word_t   i_opa,
  input  word_t   i_opb,
  input  word_t   i_mod,
  output logic    o_busy,
  output logic    o_mm_start,
  output logic    o_ic_start,
  output word_t   o_op_a,
  output word_t   o_op_b,
  output word_t   o_op_m,
  input  logic    i_mm_valid,
  input  logic    i_ic_valid,
  output logic    o_err_pulse,
  output err_t    o_err,
  output logic    o_clr
);

  logic range_ok;   // Multiply operands are legal for the modulus

  assign range_ok = (i_mod != '0) && (i_opa < i_mod) && (i_opb < i_mod);

  // Control path
  always_ff @(posedge i_clk_core0) begin
    if (i_reset) begin
      o_busy      <= 1'b0;
      o_mm_start  <= 1'b0;
      o_ic_start  <= 1'b0;
      o_err_pulse <= 1'b0;
      o_err       <= ERR_NONE;
      o_clr       <= 1'b0;
    end else begin
      o_mm_start  <= 1'b0;
      o_ic_start  <= 1'b0;
      o_err_pulse <= 1'b0;
      o_clr       <= 1'b0;
      if (i_start && !o_busy) begin
        o_busy <= 1'b1;
        o_clr  <= 1'b1;   // Collector drops the previous done
        case (i_opcode)
          OP_MODMUL: begin
            if (range_ok) begin
              o_mm_start <= 1'b1;
            end else begin
              o_err_pulse <= 1'b1;
              o_err       <= ERR_RANGE;
            end
          end
          OP_IDXCHK: o_ic_start <= 1'b1;   // Any list is a legal input
          default: begin                   // NOP and the illegal opcode
            o_err_pulse <= 1'b1;
            o_err       <= ERR_BAD_OP;
          end
        endcase
      end else if (i_mm_valid || i_ic_valid || o_err_pulse) begin
        o_busy <= 1'b0;   // Completion seen, collector sets done now too
      end
    end
  end

  // Operand copies held steady for the whole run
  always_ff @(posedge i_clk_core0) begin
    if (i_start && !o_busy) begin
      o_op_a <= i_opa;   // Also the index list
      o_op_b <= i_opb;
      o_op_m <= i_mod;
    end
  end

endmodule

/* rtl/idx_check_engine.sv */
`timescale 1ns/100ps

module idx_check_engine
  import accel_pkg::*;
(
  input  logic  i_clk_core0,
  input  logic  i_reset,
  input  logic  i_start,
  input  word_t i_idx_list,
  output logic  o_valid,
  output word_t o_result
);

  eng_state_t              state;
  logic [IDX_CNT_BITS-1:0] cnt;        // Position of the index in list_r[3:0]
  word_t                   list_r;     // Indices not yet seen, next in low nibble
  logic [IDX_SEEN-1:0]     seen;
  logic [IDX_BITS-1:0]     prev_idx;   // First index of the current pair
  logic [IDX_BITS-1:0]     cur_idx;
  logic [IDX_BITS-1:0]     first_idx;
  logic [IDX_PAIRS-1:0]    pair_bad;
  logic                    dup;

  assign cur_idx   = list_r[IDX_BITS-1:0];
  assign first_idx = i_idx_list[IDX_BITS-1:0];

  // Index 0 is taken on the start cycle, so eight steps cover the list
  always_ff @(posedge i_clk_core0) begin
    if (i_reset) begin
      state   <= IDLE;
      cnt     <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (i_start) begin
            state <= RUN;
            cnt   <= IDX_CNT_BITS'(1);
          end
        end
        RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == IDX_CNT_BITS'(IDX_COUNT - 1)) state <= DONE;   // Last index
        end
        DONE: begin
          o_valid <= 1'b1;
          state   <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Bitmap and pair compare
  always_ff @(posedge i_clk_core0) begin
    if (state == IDLE && i_start) begin
      list_r   <= i_idx_list >> IDX_BITS;
      seen     <= IDX_SEEN'(1) << first_idx;
      prev_idx <= first_idx;
      pair_bad <= '0;
      dup      <= 1'b0;
    end else if (state == RUN) begin
      list_r        <= list_r >> IDX_BITS;
      seen[cur_idx] <= 1'b1;
      dup           <= dup | seen[cur_idx];   // Value already used
      prev_idx      <= cur_idx;
      // Odd position closes pair cnt/2
      if (cnt[0]) pair_bad[cnt[IDX_CNT_BITS-1:1]] <= (prev_idx >= cur_idx);
    end else if (state == DONE) begin
      o_result <= word_t'({dup, pair_bad});   // Pair flags low, duplicate above
    end
  end

endmodule

/* rtl/mod_mul_engine.sv */
`timescale 1ns/100ps

module mod_mul_engine
  import accel_pkg::*;
(
  input  logic  i_clk_core0,
  input  logic  i_reset,
  input  logic  i_start,
  input  word_t i_a,
  input  word_t i_b,
  input  word_t i_m,
  output logic  o_valid,
  output word_t o_result
);

  eng_state_t              state;
  logic [MUL_CNT_BITS-1:0] bit_idx;   // Current bit of b, MSB first
  word_t                   a_r;
  word_t                   b_r;
  word_t                   m_r;
  logic [WORD_BITS:0]      acc;       // Partial product, kept below 2m
  word_t                   acc_red;
  word_t                   dbl_red;
  logic [WORD_BITS:0]      acc_next;

  // One compare-subtract step, valid for x below 2m
  function automatic word_t red_once(input logic [WORD_BITS:0] x, input word_t m);
    logic [WORD_BITS:0] diff;
    diff = x - {1'b0, m};
    return (x >= {1'b0, m}) ? diff[WORD_BITS-1:0] : x[WORD_BITS-1:0];
  endfunction

  // Horner step acc = 2*acc + b[i]*a
  always_comb begin
    acc_red  = red_once(acc, m_r);
    dbl_red  = red_once({acc_red, 1'b0}, m_r);
    acc_next = {1'b0, dbl_red} + (b_r[bit_idx] ? {1'b0, a_r} : '0);   // Left unreduced
  end

  // FSM
  always_ff @(posedge i_clk_core0) begin
    if (i_reset) begin
      state   <= IDLE;
      bit_idx <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (i_start) begin
            state   <= RUN;
            bit_idx <= '1;   // Start at bit 31
          end
        end
        RUN: begin
          bit_idx <= bit_idx - 1'b1;
          if (bit_idx == '0) state <= DONE;   // 32 iterations done
        end
        DONE: begin
          o_valid <= 1'b1;
          state   <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge i_clk_core0) begin
    if (state == IDLE && i_start) begin
      a_r <= i_a;
      b_r <= i_b;
      m_r <= i_m;
      acc <= '0;
    end else if (state == RUN) begin
      acc <= acc_next;
    end else if (state == DONE) begin
      o_result <= acc_red;   // Final reduction
    end
  end

endmodule

/* rtl/resp_collect.sv */
`timescale 1ns/100ps

module resp_collect
  import accel_pkg::*;
(
  input  logic  i_clk_core0,
  input  logic  i_reset,
  input  logic  i_clr,
  input  logic  i_mm_valid,
  input  word_t i_mm_result,
  input  logic  i_ic_valid,
  input  word_t i_ic_result,
  input  logic  i_err_pulse,
  input  err_t  i_err,
  output logic  o_done,
  output err_t  o_err,
  output word_t o_result
);

  // Completions win over clr, an error pulse arrives together with clr
  always_ff @(posedge i_clk_core0) begin
    if (i_reset) begin
      o_done   <= 1'b0;
      o_err    <= ERR_NONE;
      o_result <= '0;
    end else if (i_err_pulse) begin
      o_done   <= 1'b1;
      o_err    <= i_err;
      o_result <= '0;   // No result for a refused operation
    end else if (i_mm_valid) begin
      o_done   <= 1'b1;
      o_err    <= ERR_NONE;
      o_result <= i_mm_result;
    end else if (i_ic_valid) begin
      o_done   <= 1'b1;
      o_err    <= ERR_NONE;
      o_result <= i_ic_result;
    end else if (i_clr) begin
      o_done   <= 1'b0;   // New command accepted
      o_err    <= ERR_NONE;
      o_result <= '0;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module accel_tb -f flist.f -o Vaccel_tb

./obj_dir/Vaccel_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi

/* verif/accel_tb.sv */
`timescale 1ns/100ps

module accel_tb
  import accel_pkg::*;
();

  localparam int CLK_HALF   = 50;
  localparam int POLL_LIMIT = 100;   // Status reads before giving up
  localparam int MM_RUNS    = 24;
  localparam int IC_RUNS    = 12;

  logic  clk_core0;
  logic  reset;
  logic  psel, penable, pwrite;
  addr_t paddr;
  word_t pwdata;
  word_t prdata;
  logic  pready;
  logic  pslverr;

  integer seed;

  accel_top DUT (
    .i_clk_core0 (clk_core0), .i_reset   (reset),
    .i_psel      (psel),      .i_penable (penable), .i_pwrite  (pwrite),
    .i_paddr     (paddr),     .i_pwdata  (pwdata),
    .o_prdata    (prdata),    .o_pready  (pready),  .o_pslverr (pslverr)
  );

  initial clk_core0 = 1'b0;
  always #CLK_HALF clk_core0 = ~clk_core0;   // 100 ns period

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_val(input word_t got, input word_t exp, input string what);
    assert (got === exp) else begin
      $display("[ERROR] %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Setup on one falling edge and access on the next with sampling mid access
  task automatic apb_xfer(input logic wr, input addr_t addr, input word_t wdata,
                          output word_t rdata, output logic err);
    @(negedge clk_core0);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk_core0);
    penable = 1'b1;
    #(CLK_HALF / 2);
    check_val(word_t'(pready), 32'd1, "pready in access phase");
    rdata = prdata;
    err   = pslverr;
    @(negedge clk_core0);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input word_t data, input logic exp_err);
    word_t unused;
    logic  err;
    apb_xfer(1'b1, addr, data, unused, err);
    check_val(word_t'(err), word_t'(exp_err), "pslverr on write");
  endtask

  task automatic apb_read(input addr_t addr, output word_t data, input logic exp_err);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
    check_val(word_t'(err), word_t'(exp_err), "pslverr on read");
  endtask

  // Poll until done is set and busy has dropped
  task automatic wait_done(output word_t status);
    word_t st;
    int    polls;
    polls = 0;
    apb_read(REG_STATUS, st, 1'b0);
    while (!(st[1] && !st[0]) && polls < POLL_LIMIT) begin
      apb_read(REG_STATUS, st, 1'b0);
      polls++;
    end
    if (!(st[1] && !st[0])) begin
      $display("Timeout: status never showed done with busy clear");
      abort_run();
    end
    status = st;
  endtask

  // Poll until the whole status word is back to zero
  task automatic wait_idle();
    word_t st;
    int    polls;
    polls = 0;
    apb_read(REG_STATUS, st, 1'b0);
    while (st != '0 && polls < POLL_LIMIT) begin
      apb_read(REG_STATUS, st, 1'b0);
      polls++;
    end
    if (st != '0) begin
      $display("Timeout: status did not return to zero after user reset");
      abort_run();
    end
  endtask

  function automatic word_t ref_modmul(input word_t a, input word_t b, input word_t m);
    logic [63:0] prod;
    prod = 64'(a) * 64'(b);
    return word_t'(prod % 64'(m));
  endfunction

  // Pair k is index 2k against 2k+1 with index 0 in the low nibble
  function automatic word_t ref_idxchk(input word_t list);
    word_t res;
    logic  dup;
    res = '0;
    dup = 1'b0;
    for (int k = 0; k < IDX_PAIRS; k++) begin
      res[k] = list[2*k*IDX_BITS +: IDX_BITS] >= list[(2*k+1)*IDX_BITS +: IDX_BITS];
    end
    for (int i = 0; i < IDX_COUNT; i++) begin
      for (int j = i + 1; j < IDX_COUNT; j++) begin
        if (list[i*IDX_BITS +: IDX_BITS] == list[j*IDX_BITS +: IDX_BITS]) dup = 1'b1;
      end
    end
    res[IDX_PAIRS] = dup;
    return res;
  endfunction

  // Full command followed by status and result checks
  task automatic run_cmd(input opcode_t op, input word_t a, input word_t b, input word_t m,
                         input err_t exp_err, input word_t exp_res);
    word_t st;
    word_t res;
    apb_write(REG_OPA, a, 1'b0);
    apb_write(REG_OPB, b, 1'b0);
    apb_write(REG_MOD, m, 1'b0);
    apb_write(REG_CMD, word_t'(op), 1'b0);
    wait_done(st);
    check_val(st, word_t'({exp_err, 2'b10}), "status after command");
    apb_read(REG_RESULT, res, 1'b0);
    check_val(res, exp_res, "result");
  endtask

  initial begin
    word_t a, b, m, lst, rd;
    seed     = 18148;
    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    repeat (16) @(posedge clk_core0);
    @(negedge clk_core0);
    reset = 1'b0;

    // Idle state after reset
    apb_read(REG_STATUS, rd, 1'b0);
    check_val(rd, '0, "status after reset");
    apb_read(REG_RESULT, rd, 1'b0);
    check_val(rd, '0, "result after reset");

    // Random multiplies with a small modulus on every fourth run
    for (int i = 0; i < MM_RUNS; i++) begin
      m = $random(seed);
      if (i % 4 == 0) m = m & 32'h0000_00FF;
      if (m == '0) m = 32'd1;
      a = $random(seed);
      b = $random(seed);
      a = a % m;
      b = b % m;
      run_cmd(OP_MODMUL, a, b, m, ERR_NONE, ref_modmul(a, b, m));
    end
    m = 32'hFFFF_FFFF;   // Largest operands the range check allows
    run_cmd(OP_MODMUL, m - 1, m - 1, m, ERR_NONE, ref_modmul(m - 1, m - 1, m));

    // Range and opcode errors
    run_cmd(OP_MODMUL, 32'd77, 32'd5, 32'd77, ERR_RANGE, '0);
    run_cmd(OP_MODMUL, 32'd3, 32'd900, 32'd77, ERR_RANGE, '0);
    run_cmd(OP_MODMUL, 32'd0, 32'd0, 32'd0, ERR_RANGE, '0);
    run_cmd(OP_NOP, 32'd1, 32'd1, 32'd7, ERR_BAD_OP, '0);
    run_cmd(opcode_t'(3), 32'd1, 32'd1, 32'd7, ERR_BAD_OP, '0);

    // Sorted, reversed-pair, repeated and all-equal index lists before random ones
    lst = 32'h7654_3210;
    run_cmd(OP_IDXCHK, lst, '0, '0, ERR_NONE, ref_idxchk(lst));
    lst = 32'h6745_2301;
    run_cmd(OP_IDXCHK, lst, '0, '0, ERR_NONE, ref_idxchk(lst));
    lst = 32'h7654_3200;
    run_cmd(OP_IDXCHK, lst, '0, '0, ERR_NONE, ref_idxchk(lst));
    lst = 32'hFFFF_FFFF;
    run_cmd(OP_IDXCHK, lst, '0, '0, ERR_NONE, ref_idxchk(lst));
    for (int i = 0; i < IC_RUNS; i++) begin
      lst = $random(seed);
      run_cmd(OP_IDXCHK, lst, '0, '0, ERR_NONE, ref_idxchk(lst));
    end

    // Refused accesses while a multiply runs
    a = 32'h0123_4567;
    b = 32'h0765_4321;
    m = 32'hF000_0001;
    apb_write(REG_OPA, a, 1'b0);
    apb_write(REG_OPB, b, 1'b0);
    apb_write(REG_MOD, m, 1'b0);
    apb_write(REG_CMD, word_t'(OP_MODMUL), 1'b0);
    apb_read(REG_STATUS, rd, 1'b0);
    check_val(rd, 32'd1, "status while busy");
    apb_write(REG_CMD, word_t'(OP_IDXCHK), 1'b1);   // Busy refusal
    apb_read(8'h18, rd, 1'b1);                      // Unmapped read
    apb_write(8'h40, 32'hDEAD_BEEF, 1'b1);          // Unmapped write
    wait_done(rd);
    check_val(rd, word_t'({ERR_NONE, 2'b10}), "status after refused accesses");
    apb_read(REG_RESULT, rd, 1'b0);
    check_val(rd, ref_modmul(a, b, m), "result after refused accesses");

    // User reset in the middle of a multiply
    apb_write(REG_CMD, word_t'(OP_MODMUL), 1'b0);
    apb_read(REG_STATUS, rd, 1'b0);
    check_val(rd, 32'd1, "status before user reset");
    apb_write(REG_CMD, 32'h8000_0000, 1'b0);   // Reset bit passes while busy
    wait_idle();
    apb_read(REG_RESULT, rd, 1'b0);
    check_val(rd, '0, "result after user reset");
    run_cmd(OP_MODMUL, a, b, m, ERR_NONE, ref_modmul(a, b, m));

    $display("Verification passed");
    $finish;
  end

endmodule
